// ==== sources.f ====
common/lm80c_pkg.sv
boot/boot_ctrl.sv
boot/mem_eraser.sv
boot/sig_checker.sv
verilog/mem_arbiter.sv
verilog/io_decoder.sv
verilog/audio_dac.sv
verilog/lm80c_sys.sv
bench/lm80c_sys_assert.sv
bench/lm80c_sys_tb.sv

// ==== Bender.yml ====
package:
  name: lm80c_sys

sources:
  # Package first, then RTL blocks and top level
  - common/lm80c_pkg.sv
  - boot/boot_ctrl.sv
  - boot/mem_eraser.sv
  - boot/sig_checker.sv
  - verilog/mem_arbiter.sv
  - verilog/io_decoder.sv
  - verilog/audio_dac.sv
  - verilog/lm80c_sys.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - bench/lm80c_sys_assert.sv
      - bench/lm80c_sys_tb.sv

// ==== bench/lm80c_sys_tb.sv ====
/* Testbench for the LM80C system glue
   Clock, reset, synchronous RAM model, download and boot checks,
   CPU bus cycle table, reset key, audio density table, watchdog */

`timescale 1ns/1ps

module lm80c_sys_tb;
	import lm80c_pkg::*;

	localparam int CLK_HALF = 20;   // 40 ns period
	localparam int DRV_DLY  = 5;    // Inputs change after the rising edge
	localparam int SMP_DLY  = 20;   // Settling time before a check
	localparam int RST_CYC  = 8;
	localparam int N_DL     = 256;  // Downloaded ROM bytes
	localparam int BOOT_CYC = 32800;
	localparam int N_ROWS   = 22;
	localparam int N_AUD    = 6;
	localparam int AUD_CYC  = 1024;  // One full accumulator period
	localparam int RUN_CYC  = RST_CYC + 2 * BOOT_CYC + 2 * (N_DL + 4) + 2 * N_ROWS + 16
	                        + N_AUD * (AUD_CYC + 4);
	localparam int WD_CYC   = 2 * RUN_CYC;  // Doubled margin

	// Bus cycle kinds
	localparam logic [1:0] OP_MWR = 2'd0;
	localparam logic [1:0] OP_MRD = 2'd1;
	localparam logic [1:0] OP_IWR = 2'd2;
	localparam logic [1:0] OP_IRD = 2'd3;

	typedef struct packed {
		logic [1:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;      // CPU write data
		logic [7:0]  exp_data;  // Read data or model byte after a write
		logic [4:0]  exp_sel;   // pio ctc sio vdp psg
		logic        exp_led;   // LED after the cycle
	} bus_row_t;

	localparam cpu_bus_t BUS_IDLE = '{addr: '0, dout: '0, rd_n: 1'b1, wr_n: 1'b1,
	                                  mreq_n: 1'b1, iorq_n: 1'b1};

	// DUT inputs
	logic      CLOCK;
	logic      rst_n_i;
	dl_port_t  dl_i;
	logic      boot_done_i;
	logic      erase_req_i;
	logic      reset_key_i;
	cpu_bus_t  cpu_i;
	byte_t     mem_rdata;
	psg_chan_t psg_i;

	// DUT outputs
	mem_req_t  mem_o;
	byte_t     cpu_din_o;
	logic      cpu_rst_n_o;
	logic      cpu_wait_n_o;
	io_sel_t   io_sel_o;
	logic      led_o;
	logic      audio_o;

	byte_t       mem [0:65535];     // 64 KiB memory model
	byte_t       dl_img [0:N_DL-1]; // Image sent over the download port
	mem_req_t    mreq_s;            // Request seen at the clock edge
	logic [31:0] lcg_state;
	int          errors;
	int          checks;

	// After boot two the ROM holds F3 C3 A5 02, LED starts low
	bus_row_t bus_tab [N_ROWS] = '{
		'{OP_MWR, 16'h8000, 8'h11, 8'h11, 5'b00000, 1'b0},
		'{OP_MRD, 16'h8000, 8'h00, 8'h11, 5'b00000, 1'b0},
		'{OP_MWR, 16'hFFFF, 8'hEE, 8'hEE, 5'b00000, 1'b0},
		'{OP_MRD, 16'hFFFF, 8'h00, 8'hEE, 5'b00000, 1'b0},
		'{OP_MWR, 16'h0001, 8'h77, 8'hC3, 5'b00000, 1'b0},  // ROM keeps its byte
		'{OP_MRD, 16'h0001, 8'h00, 8'hC3, 5'b00000, 1'b0},
		'{OP_MWR, 16'h0002, 8'h00, 8'hA5, 5'b00000, 1'b0},
		'{OP_MRD, 16'hC000, 8'h00, 8'h00, 5'b00000, 1'b0},  // Erased RAM
		'{OP_MRD, 16'h0000, 8'h00, 8'hF3, 5'b00000, 1'b0},  // F3 stays on read data
		'{OP_IWR, 16'h0005, 8'h12, 8'h00, 5'b10000, 1'b0},  // PIO
		'{OP_IRD, 16'h0013, 8'h00, 8'h00, 5'b01000, 1'b0},  // CTC
		'{OP_IRD, 16'h0021, 8'h00, 8'h00, 5'b00100, 1'b0},  // SIO
		'{OP_IWR, 16'h0030, 8'h00, 8'h00, 5'b00010, 1'b0},  // VDP
		'{OP_IRD, 16'h0042, 8'h00, 8'h00, 5'b00001, 1'b0},  // PSG
		'{OP_IRD, 16'h0050, 8'h00, 8'h00, 5'b00000, 1'b0},  // Unmapped
		'{OP_IWR, 16'h0060, 8'h01, 8'h00, 5'b00000, 1'b0},
		'{OP_IWR, 16'h0070, 8'h01, 8'h00, 5'b00000, 1'b1},  // Toggle on
		'{OP_IWR, 16'h0070, 8'h02, 8'h00, 5'b00000, 1'b1},  // Bit 0 clear
		'{OP_IWR, 16'h1271, 8'h03, 8'h00, 5'b00000, 1'b0},  // Upper byte ignored
		'{OP_IRD, 16'h00F0, 8'h00, 8'h00, 5'b00000, 1'b0},
		'{OP_IWR, 16'h0070, 8'hFF, 8'h00, 5'b00000, 1'b1},
		'{OP_IRD, 16'h0070, 8'h00, 8'h00, 5'b00000, 1'b1}   // Read does not toggle
	};

	// Constant channel triples a b c
	psg_chan_t aud_tab [N_AUD] = '{
		'{8'h00, 8'h00, 8'h00},
		'{8'h01, 8'h00, 8'h00},
		'{8'h80, 8'h40, 8'h20},
		'{8'hFF, 8'hFF, 8'hFF},
		'{8'h12, 8'h34, 8'h56},
		'{8'hFF, 8'h00, 8'h7F}
	};

	lm80c_sys DUT (
		.CLOCK        (CLOCK),
		.rst_n_i      (rst_n_i),
		.dl_i         (dl_i),
		.boot_done_i  (boot_done_i),
		.erase_req_i  (erase_req_i),
		.reset_key_i  (reset_key_i),
		.cpu_i        (cpu_i),
		.mem_rdata_i  (mem_rdata),
		.psg_i        (psg_i),
		.mem_o        (mem_o),
		.cpu_din_o    (cpu_din_o),
		.cpu_rst_n_o  (cpu_rst_n_o),
		.cpu_wait_n_o (cpu_wait_n_o),
		.io_sel_o     (io_sel_o),
		.led_o        (led_o),
		.audio_o      (audio_o)
	);

	initial begin
		CLOCK = 1'b0;
		forever #CLK_HALF CLOCK = ~CLOCK;
	end

	// Synchronous RAM, read data one cycle after re
	always @(posedge CLOCK) begin
		mreq_s = mem_o;
		#DRV_DLY;
		if (mreq_s.we) mem[mreq_s.addr] = mreq_s.wdata;
		if (mreq_s.re) mem_rdata = mem[mreq_s.addr];
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic step();
		@(posedge CLOCK);
		#DRV_DLY;
	endtask

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// One-cycle claim of the port, then one byte per cycle
	task automatic download();
		step();
		dl_i        = '0;
		dl_i.active = 1'b1;
		for (int i = 0; i < N_DL; i++) begin
			step();
			dl_i.we   = 1'b1;
			dl_i.addr = addr_t'(i);
			dl_i.data = dl_img[i];
		end
		step();
		dl_i = '0;  // Falling active starts the erase
	endtask

	task automatic wait_boot();
		int cyc;
		cyc = 0;
		while (cpu_wait_n_o !== 1'b1 && cyc < BOOT_CYC) begin
			step();
			cyc++;
		end
		if (cpu_wait_n_o !== 1'b1) begin
			errors++;
			$display("Boot sequence did not reach the run state within %0d cycles", BOOT_CYC);
		end
	endtask

	task automatic check_boot(input logic exp_led);
		#SMP_DLY;
		check_val("cpu_rst_n_o", 16'd1, 16'(cpu_rst_n_o));
		check_val("led_o", 16'(exp_led), 16'(led_o));
		for (int a = 32'h8000; a < 32'h10000; a++) begin  // Whole RAM half zero
			check_val($sformatf("mem[%h]", a[15:0]), 16'h0000, 16'(mem[a]));
		end
		for (int a = 0; a < N_DL; a++) begin
			check_val($sformatf("mem[%h]", a[15:0]), 16'(dl_img[a]), 16'(mem[a]));
		end
	endtask

	task automatic apply_row(input bus_row_t r);
		step();
		cpu_i      = BUS_IDLE;
		cpu_i.addr = r.addr;
		cpu_i.dout = r.data;
		case (r.op)
			OP_MWR: begin
				cpu_i.mreq_n = 1'b0;
				cpu_i.wr_n   = 1'b0;
			end
			OP_MRD: begin
				cpu_i.mreq_n = 1'b0;
				cpu_i.rd_n   = 1'b0;
			end
			OP_IWR: begin
				cpu_i.iorq_n = 1'b0;
				cpu_i.wr_n   = 1'b0;
			end
			default: begin
				cpu_i.iorq_n = 1'b0;
				cpu_i.rd_n   = 1'b0;
			end
		endcase
		#SMP_DLY;
		check_val("io_sel_o", 16'(r.exp_sel), 16'(io_sel_o));
		if (r.op == OP_IRD) check_val("cpu_din_o", 16'(r.exp_data), 16'(cpu_din_o));
		step();
		if (r.op != OP_MRD) cpu_i = BUS_IDLE;  // Reads hold for the data cycle
		#SMP_DLY;
		if (r.op == OP_MRD) check_val("cpu_din_o", 16'(r.exp_data), 16'(cpu_din_o));
		if (r.op == OP_MWR) begin
			check_val($sformatf("mem[%h]", r.addr), 16'(r.exp_data), 16'(mem[r.addr]));
		end
		check_val("led_o", 16'(r.exp_led), 16'(led_o));
	endtask

	// Ones over one accumulator period equal the channel sum
	task automatic audio_run(input psg_chan_t p);
		int ones;
		int exp_sum;
		ones    = 0;
		exp_sum = int'(p.a) + int'(p.b) + int'(p.c);
		step();
		rst_n_i = 1'b0;  // Clears the accumulator
		psg_i   = p;
		step();
		step();
		rst_n_i = 1'b1;
		repeat (AUD_CYC) begin
			step();
			if (audio_o === 1'b1) ones++;
		end
		check_val($sformatf("audio_o ones %h %h %h", p.a, p.b, p.c), 16'(exp_sum), 16'(ones));
	endtask

	initial begin
		rst_n_i     = 1'b0;
		dl_i        = '0;
		boot_done_i = 1'b0;
		erase_req_i = 1'b0;
		reset_key_i = 1'b0;
		cpu_i       = BUS_IDLE;
		mem_rdata   = '0;
		psg_i       = '0;
		errors      = 0;
		checks      = 0;
		lcg_state   = 32'd59271;
		for (int a = 0; a < 65536; a++) begin
			lcg_state = lcg_next(lcg_state);
			mem[a]    = lcg_state[23:16] ^ a[7:0] ^ a[15:8];  // Spread over all address bits
		end
		dl_img[0] = 8'hF3;  // Signature bytes
		dl_img[1] = 8'hC3;
		dl_img[2] = 8'h5A;
		dl_img[3] = 8'h02;
		for (int i = 4; i < N_DL; i++) begin
			lcg_state = lcg_next(lcg_state);
			dl_img[i] = lcg_state[23:16];
		end

		repeat (RST_CYC) step();
		rst_n_i = 1'b1;
		#SMP_DLY;
		check_val("cpu_rst_n_o", 16'd0, 16'(cpu_rst_n_o));
		check_val("cpu_wait_n_o", 16'd0, 16'(cpu_wait_n_o));
		check_val("mem_o.we", 16'd0, 16'(mem_o.we));
		check_val("mem_o.re", 16'd0, 16'(mem_o.re));
		check_val("led_o", 16'd0, 16'(led_o));
		check_val("audio_o", 16'd0, 16'(audio_o));

		download();  // Good image
		wait_boot();
		check_boot(1'b1);

		step();
		reset_key_i = 1'b1;  // CPU held in reset
		repeat (4) begin
			#SMP_DLY;
			check_val("cpu_rst_n_o", 16'd0, 16'(cpu_rst_n_o));
			step();
		end
		reset_key_i = 1'b0;
		#SMP_DLY;
		check_val("cpu_rst_n_o", 16'd1, 16'(cpu_rst_n_o));
		check_val("cpu_wait_n_o", 16'd1, 16'(cpu_wait_n_o));

		dl_img[2] = dl_img[2] ^ 8'hFF;  // Corrupt third byte
		download();
		wait_boot();
		check_boot(1'b0);

		for (int r = 0; r < N_ROWS; r++) apply_row(bus_tab[r]);
		step();
		cpu_i = BUS_IDLE;

		for (int k = 0; k < N_AUD; k++) audio_run(aud_tab[k]);

		errors = errors + DUT.u_assert.fail_cnt;
		$display("Checks %0d, errors %0d, assertion failures %0d",
		         checks, errors, DUT.u_assert.fail_cnt);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WD_CYC) @(posedge CLOCK);
		$display("Watchdog expired after %0d cycles, run stopped", WD_CYC);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== bench/lm80c_sys_assert.sv ====
/* Concurrent assertions on memory port and boot control
   Bound into the system top level */

`timescale 1ns/1ps

module lm80c_sys_assert (
	input logic                  CLOCK,
	input logic                  rst_n_i,
	input lm80c_pkg::mem_req_t   mem_i,
	input lm80c_pkg::bus_owner_t owner_i,
	input logic                  cpu_wait_n_i,
	input logic                  check_done_i
);
	import lm80c_pkg::*;

	int fail_cnt = 0;  // Read by the testbench

	// Never write and read in one cycle
	assert property (@(posedge CLOCK) disable iff (!rst_n_i) !(mem_i.we && mem_i.re))
		else begin
			fail_cnt++;
			$error("Memory port has we and re high together");
		end

	// CPU runs only as bus owner
	assert property (@(posedge CLOCK) disable iff (!rst_n_i) cpu_wait_n_i |-> owner_i == OWN_CPU)
		else begin
			fail_cnt++;
			$error("CPU released from wait while it does not own the bus");
		end

	// BOOT_RUN the cycle after the check, wait released only there
	assert property (@(posedge CLOCK) disable iff (!rst_n_i) check_done_i |=> cpu_wait_n_i)
		else begin
			fail_cnt++;
			$error("Run state not entered the cycle after check_done");
		end

endmodule

bind lm80c_sys lm80c_sys_assert u_assert (
	.CLOCK        (CLOCK),
	.rst_n_i      (rst_n_i),
	.mem_i        (mem_o),
	.owner_i      (bus_owner),
	.cpu_wait_n_i (cpu_wait_n_o),
	.check_done_i (check_done)
);

// ==== verilog/lm80c_sys.sv ====
/* LM80C system glue top level
   Boot sequencing, memory arbitration, I/O decode, audio DAC */

`timescale 1ns/1ps

module lm80c_sys (
	input  logic                 CLOCK,
	input  logic                 rst_n_i,
	input  lm80c_pkg::dl_port_t  dl_i,
	input  logic                 boot_done_i,
	input  logic                 erase_req_i,
	input  logic                 reset_key_i,
	input  lm80c_pkg::cpu_bus_t  cpu_i,
	input  lm80c_pkg::byte_t     mem_rdata_i,
	input  lm80c_pkg::psg_chan_t psg_i,
	output lm80c_pkg::mem_req_t  mem_o,
	output lm80c_pkg::byte_t     cpu_din_o,
	output logic                 cpu_rst_n_o,
	output logic                 cpu_wait_n_o,
	output lm80c_pkg::io_sel_t   io_sel_o,
	output logic                 led_o,
	output logic                 audio_o
);
	import lm80c_pkg::*;

	logic       erase_start;
	logic       check_start;
	logic       erase_done;
	logic       check_done;
	logic       sig_match;   // Valid with check_done
	bus_owner_t bus_owner;
	mem_req_t   erase_req;
	mem_req_t   check_req;

	boot_ctrl u_boot_ctrl (
		.CLOCK         (CLOCK),
		.rst_n_i       (rst_n_i),
		.dl_active_i   (dl_i.active),
		.boot_done_i   (boot_done_i),
		.erase_req_i   (erase_req_i),
		.reset_key_i   (reset_key_i),
		.erase_done_i  (erase_done),
		.check_done_i  (check_done),
		.erase_start_o (erase_start),
		.check_start_o (check_start),
		.bus_owner_o   (bus_owner),
		.cpu_rst_n_o   (cpu_rst_n_o),
		.cpu_wait_n_o  (cpu_wait_n_o)
	);

	mem_eraser u_mem_eraser (
		.CLOCK   (CLOCK),
		.rst_n_i (rst_n_i),
		.start_i (erase_start),
		.req_o   (erase_req),
		.done_o  (erase_done)
	);

	sig_checker u_sig_checker (
		.CLOCK   (CLOCK),
		.rst_n_i (rst_n_i),
		.start_i (check_start),
		.rdata_i (mem_rdata_i),
		.req_o   (check_req),
		.done_o  (check_done),
		.match_o (sig_match)
	);

	mem_arbiter u_mem_arbiter (
		.owner_i (bus_owner),
		.dl_i    (dl_i),
		.erase_i (erase_req),
		.check_i (check_req),
		.cpu_i   (cpu_i),
		.mem_o   (mem_o)
	);

	io_decoder u_io_decoder (
		.CLOCK         (CLOCK),
		.rst_n_i       (rst_n_i),
		.cpu_i         (cpu_i),
		.mem_rdata_i   (mem_rdata_i),
		.check_start_i (check_start),
		.check_done_i  (check_done),
		.sig_match_i   (sig_match),
		.io_sel_o      (io_sel_o),
		.cpu_din_o     (cpu_din_o),
		.led_o         (led_o)
	);

	audio_dac u_audio_dac (
		.CLOCK   (CLOCK),
		.rst_n_i (rst_n_i),
		.psg_i   (psg_i),
		.audio_o (audio_o)
	);

endmodule

// ==== verilog/audio_dac.sv ====
/* Three-channel mixer and first-order sigma-delta DAC */

`timescale 1ns/1ps

module audio_dac (
	input  logic                 CLOCK,
	input  logic                 rst_n_i,
	input  lm80c_pkg::psg_chan_t psg_i,
	output logic                 audio_o
);
	import lm80c_pkg::*;

	audio_sum_t       mix;
	logic [SUM_W:0]   acc_q;  // Residue plus carry

	// Zero extend before adding
	assign mix = SUM_W'(psg_i.a) + SUM_W'(psg_i.b) + SUM_W'(psg_i.c);

	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_q <= '0;
		end else begin
			acc_q <= {1'b0, acc_q[SUM_W-1:0]} + {1'b0, mix};  // Carry dropped each cycle
		end
	end

	assign audio_o = acc_q[SUM_W];  // Registered carry, density mix/1024

endmodule

// ==== verilog/io_decoder.sv ====
/* I/O address decoder
   Peripheral chip selects, CPU read-data mux, debug LED register */

`timescale 1ns/1ps

module io_decoder (
	input  logic                CLOCK,
	input  logic                rst_n_i,
	input  lm80c_pkg::cpu_bus_t cpu_i,
	input  lm80c_pkg::byte_t    mem_rdata_i,
	input  logic                check_start_i,
	input  logic                check_done_i,
	input  logic                sig_match_i,
	output lm80c_pkg::io_sel_t  io_sel_o,
	output lm80c_pkg::byte_t    cpu_din_o,
	output logic                led_o
);
	import lm80c_pkg::*;

	logic       io_cycle;   // I/O request without memory request
	logic [3:0] port_nib;
	logic       led_wr;     // Write to the LED port with bit 0 set
	logic       led_wr_q;

	assign io_cycle = !cpu_i.iorq_n && cpu_i.mreq_n;
	assign port_nib = cpu_i.addr[7:4];  // Z80 I/O uses the low address byte

	always_comb begin
		io_sel_o.pio = io_cycle && (port_nib == IO_PIO);
		io_sel_o.ctc = io_cycle && (port_nib == IO_CTC);
		io_sel_o.sio = io_cycle && (port_nib == IO_SIO);
		io_sel_o.vdp = io_cycle && (port_nib == IO_VDP);
		io_sel_o.psg = io_cycle && (port_nib == IO_PSG);
	end

	// Peripherals are absent, I/O reads give zero
	assign cpu_din_o = cpu_i.iorq_n ? mem_rdata_i : '0;

	assign led_wr = io_cycle && (port_nib == IO_LED) && !cpu_i.wr_n && cpu_i.dout[0];

	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			led_o    <= 1'b0;
			led_wr_q <= 1'b0;
		end else begin
			led_wr_q <= led_wr;
			if (check_start_i) begin
				led_o <= 1'b0;  // Cleared for a new check
			end else if (check_done_i) begin
				led_o <= sig_match_i;
			end else if (led_wr && !led_wr_q) begin
				led_o <= !led_o;  // Once per write strobe
			end
		end
	end

endmodule

// ==== verilog/mem_arbiter.sv ====
/* Memory port arbiter
   Owner mux and CPU strobe qualification with ROM write protect */

`timescale 1ns/1ps

module mem_arbiter (
	input  lm80c_pkg::bus_owner_t owner_i,
	input  lm80c_pkg::dl_port_t   dl_i,
	input  lm80c_pkg::mem_req_t   erase_i,
	input  lm80c_pkg::mem_req_t   check_i,
	input  lm80c_pkg::cpu_bus_t   cpu_i,
	output lm80c_pkg::mem_req_t   mem_o
);
	import lm80c_pkg::*;

	mem_req_t cpu_req;
	mem_req_t dl_req;
	logic     cpu_mem;  // Memory cycle on the CPU bus

	assign cpu_mem = !cpu_i.mreq_n;

	// Z80 strobes to a memory request
	always_comb begin
		cpu_req.addr  = cpu_i.addr;
		cpu_req.wdata = cpu_i.dout;
		cpu_req.we    = cpu_mem && !cpu_i.wr_n && (cpu_i.addr >= RAM_BASE);  // ROM is read only
		cpu_req.re    = cpu_mem && !cpu_i.rd_n;
	end

	always_comb begin
		dl_req.addr  = dl_i.addr;
		dl_req.wdata = dl_i.data;
		dl_req.we    = dl_i.we && dl_i.active;  // No writes outside a download
		dl_req.re    = 1'b0;
	end

	always_comb begin
		case (owner_i)
			OWN_LOAD:  mem_o = dl_req;
			OWN_ERASE: mem_o = erase_i;
			OWN_CHECK: mem_o = check_i;
			default:   mem_o = cpu_req;
		endcase
	end

endmodule

// ==== boot/sig_checker.sv ====
/* ROM signature checker
   Reads addresses 0 to 3 and compares them with SIG_BYTES */

`timescale 1ns/1ps

module sig_checker (
	input  logic                CLOCK,
	input  logic                rst_n_i,
	input  logic                start_i,
	input  lm80c_pkg::byte_t    rdata_i,
	output lm80c_pkg::mem_req_t req_o,
	output logic                done_o,
	output logic                match_o
);
	import lm80c_pkg::*;

	logic       rd_busy_q;  // Read phase
	logic [1:0] rd_idx_q;   // Address being read
	logic       cmp_vld_q;  // Read data valid this cycle
	logic [1:0] cmp_idx_q;  // Index of the returning byte
	logic       all_ok_q;   // All bytes so far matched
	logic       byte_ok;

	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_busy_q <= 1'b0;
			rd_idx_q  <= '0;
			cmp_vld_q <= 1'b0;
			all_ok_q  <= 1'b0;
		end else begin
			cmp_vld_q <= rd_busy_q;  // Data comes back one cycle later
			if (start_i) begin
				rd_busy_q <= 1'b1;
				rd_idx_q  <= '0;
				all_ok_q  <= 1'b1;
			end else begin
				if (rd_busy_q) begin
					rd_idx_q <= rd_idx_q + 1'b1;
					if (rd_idx_q == 2'd3) rd_busy_q <= 1'b0;
				end
				if (cmp_vld_q) all_ok_q <= all_ok_q && byte_ok;
			end
		end
	end

	// Index follows the read by one cycle
	always_ff @(posedge CLOCK) begin
		cmp_idx_q <= rd_idx_q;
	end

	assign byte_ok = (rdata_i == SIG_BYTES[cmp_idx_q]);

	always_comb begin
		req_o.addr  = ADDR_W'(rd_idx_q);
		req_o.wdata = '0;
		req_o.we    = 1'b0;  // Read only
		req_o.re    = rd_busy_q;
	end

	// Done with the last compare, match includes that byte
	assign done_o  = cmp_vld_q && (cmp_idx_q == 2'd3);
	assign match_o = all_ok_q && byte_ok;

endmodule

// ==== boot/mem_eraser.sv ====
/* RAM eraser
   Writes zero from RAM_BASE to RAM_LAST once per start pulse */

`timescale 1ns/1ps

module mem_eraser (
	input  logic                CLOCK,
	input  logic                rst_n_i,
	input  logic                start_i,
	output lm80c_pkg::mem_req_t req_o,
	output logic                done_o
);
	import lm80c_pkg::*;

	logic  busy_q;
	addr_t addr_q;  // Next address to clear

	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			addr_q <= RAM_BASE;
		end else if (start_i) begin
			busy_q <= 1'b1;
			addr_q <= RAM_BASE;  // Restart from bottom of RAM
		end else if (busy_q) begin
			addr_q <= addr_q + 1'b1;
			if (addr_q == RAM_LAST) busy_q <= 1'b0;
		end
	end

	// One write per busy cycle
	always_comb begin
		req_o.addr  = addr_q;
		req_o.wdata = '0;
		req_o.we    = busy_q;
		req_o.re    = 1'b0;
	end

	// Last write cycle
	assign done_o = busy_q && (addr_q == RAM_LAST);

endmodule

// ==== boot/boot_ctrl.sv ====
/* Boot and run sequencing FSM
   Bus owner select, CPU reset and wait control */

`timescale 1ns/1ps

module boot_ctrl (
	input  logic                  CLOCK,
	input  logic                  rst_n_i,
	input  logic                  dl_active_i,
	input  logic                  boot_done_i,
	input  logic                  erase_req_i,   // One-cycle pulse
	input  logic                  reset_key_i,
	input  logic                  erase_done_i,
	input  logic                  check_done_i,
	output logic                  erase_start_o,
	output logic                  check_start_o,
	output lm80c_pkg::bus_owner_t bus_owner_o,
	output logic                  cpu_rst_n_o,
	output logic                  cpu_wait_n_o
);
	import lm80c_pkg::*;

	boot_state_t state_q, state_d;
	logic        erase_start_d;
	logic        check_start_d;

	always_comb begin
		state_d       = state_q;
		erase_start_d = 1'b0;
		check_start_d = 1'b0;
		case (state_q)
			BOOT_IDLE: begin
				if (dl_active_i) begin
					state_d = BOOT_LOAD;
				end else if (boot_done_i) begin  // ROM already in place
					state_d       = BOOT_ERASE;
					erase_start_d = 1'b1;
				end
			end
			BOOT_LOAD: begin
				if (!dl_active_i) begin  // Download finished
					state_d       = BOOT_ERASE;
					erase_start_d = 1'b1;
				end
			end
			BOOT_ERASE: begin
				if (erase_done_i) begin
					state_d       = BOOT_CHECK;
					check_start_d = 1'b1;
				end
			end
			BOOT_CHECK: begin
				if (check_done_i) state_d = BOOT_RUN;
			end
			BOOT_RUN: begin
				if (dl_active_i) begin  // New image replaces the ROM
					state_d = BOOT_LOAD;
				end else if (erase_req_i) begin
					state_d       = BOOT_ERASE;
					erase_start_d = 1'b1;
				end
			end
			default: state_d = BOOT_IDLE;
		endcase
	end

	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q       <= BOOT_IDLE;
			erase_start_o <= 1'b0;
			check_start_o <= 1'b0;
		end else begin
			state_q       <= state_d;
			erase_start_o <= erase_start_d;  // High in first ERASE cycle
			check_start_o <= check_start_d;  // High in first CHECK cycle
		end
	end

	// Owner follows state
	always_comb begin
		case (state_q)
			BOOT_IDLE:  bus_owner_o = OWN_LOAD;  // Downloader parks on the port before first boot
			BOOT_LOAD:  bus_owner_o = OWN_LOAD;
			BOOT_ERASE: bus_owner_o = OWN_ERASE;
			BOOT_CHECK: bus_owner_o = OWN_CHECK;
			default:    bus_owner_o = OWN_CPU;
		endcase
	end

	// CPU only runs in BOOT_RUN
	assign cpu_wait_n_o = (state_q == BOOT_RUN);
	assign cpu_rst_n_o  = (state_q == BOOT_RUN) && !reset_key_i;  // Reset key overrides

endmodule

// ==== common/lm80c_pkg.sv ====
/* Shared definitions for the LM80C system glue
   Bus widths, memory map, ROM signature, I/O port codes,
   boot state and bus owner enums, bus structs */

package lm80c_pkg;

	localparam int ADDR_W = 16;  // Z80 address space
	localparam int DATA_W = 8;
	localparam int SUM_W  = 10;  // Three 8-bit channels need 10 bits

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [SUM_W-1:0]  audio_sum_t;

	// Upper half of memory is RAM
	localparam addr_t RAM_BASE = 16'h8000;
	localparam addr_t RAM_LAST = 16'hFFFF;

	// Expected first four ROM bytes, index 0 at address 0
	localparam byte_t [0:3] SIG_BYTES = {8'hF3, 8'hC3, 8'h5A, 8'h02};

	// Upper nibble of the I/O address
	localparam logic [3:0] IO_PIO = 4'h0;
	localparam logic [3:0] IO_CTC = 4'h1;
	localparam logic [3:0] IO_SIO = 4'h2;
	localparam logic [3:0] IO_VDP = 4'h3;
	localparam logic [3:0] IO_PSG = 4'h4;
	localparam logic [3:0] IO_LED = 4'h7;  // Debug LED port 70h

	typedef enum logic [2:0] {
		BOOT_IDLE,
		BOOT_LOAD,
		BOOT_ERASE,
		BOOT_CHECK,
		BOOT_RUN
	} boot_state_t;

	typedef enum logic [1:0] {
		OWN_CPU,
		OWN_LOAD,
		OWN_ERASE,
		OWN_CHECK
	} bus_owner_t;

	// One memory port request
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  we;
		logic  re;
	} mem_req_t;

	// Z80 side of the bus, strobes active low
	typedef struct packed {
		addr_t addr;
		byte_t dout;
		logic  rd_n;
		logic  wr_n;
		logic  mreq_n;
		logic  iorq_n;
	} cpu_bus_t;

	typedef struct packed {
		logic  active;  // Download in progress
		logic  we;
		addr_t addr;
		byte_t data;
	} dl_port_t;

	typedef struct packed {
		logic pio;
		logic ctc;
		logic sio;
		logic vdp;
		logic psg;
	} io_sel_t;

	typedef struct packed {
		byte_t a;
		byte_t b;
		byte_t c;
	} psg_chan_t;

endpackage
